// ==== filelist.f ====
+incdir+rtl
rtl/thumb_ctrl_pkg.sv
rtl/thumb_instr_decode.sv
rtl/multi_transfer_sequencer.sv
rtl/thumb_controller.sv
verification/tb_clock_gen.sv
verification/thumb_controller_props.sv
verification/thumb_controller_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module thumb_controller_tb \
    -f filelist.f -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vthumb_controller_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== verification/thumb_controller_tb.sv ====
`timescale 1ns/1ps

module thumb_controller_tb;

    localparam int SEQ_TIMEOUT   = 20;
    localparam int RESET_TIMEOUT = 16;

    logic                          clk;
    logic                          reset;
    logic                          is_valid;
    thumb_ctrl_pkg::instr_t        instruction;

    logic                          update_flag;
    logic                          mem_write_en;
    logic                          mem_read_en;
    logic                          reg_write_en;
    thumb_ctrl_pkg::reg_data_src_t reg_data_src;
    thumb_ctrl_pkg::alu_src_t      alu_src_a;
    thumb_ctrl_pkg::alu_src_t      alu_src_b;
    thumb_ctrl_pkg::alu_op_t       alu_op;
    logic                          stall;
    logic                          reg_addr_from_ctrl;
    logic                          dest_addr_from_ctrl;
    thumb_ctrl_pkg::word_t         accumulator_imm;
    thumb_ctrl_pkg::reg_addr_t     reg_file_addr;

    // model outputs for one single-cycle instruction
    logic                          exp_flag;
    logic                          exp_mw;
    logic                          exp_mr;
    logic                          exp_rw;
    thumb_ctrl_pkg::reg_data_src_t exp_src;
    thumb_ctrl_pkg::alu_src_t      exp_a;
    thumb_ctrl_pkg::alu_src_t      exp_b;
    thumb_ctrl_pkg::alu_op_t       exp_op;

    string                         test_name;
    int                            tests;
    int                            checks;
    int                            errors;
    int                            test_checks;
    int                            test_errors;
    int                            cycles;
    logic [31:0]                   lcg_state;
    logic [31:0]                   r;
    thumb_ctrl_pkg::instr_t        instr;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    thumb_controller u_thumb_controller (
        .clk_i                 (clk),
        .reset_i               (reset),
        .is_valid_i            (is_valid),
        .instruction_i         (instruction),
        .update_flag_o         (update_flag),
        .mem_write_en_o        (mem_write_en),
        .mem_read_en_o         (mem_read_en),
        .reg_write_en_o        (reg_write_en),
        .reg_data_src_o        (reg_data_src),
        .alu_src_a_o           (alu_src_a),
        .alu_src_b_o           (alu_src_b),
        .alu_op_o              (alu_op),
        .stall_o               (stall),
        .reg_addr_from_ctrl_o  (reg_addr_from_ctrl),
        .dest_addr_from_ctrl_o (dest_addr_from_ctrl),
        .accumulator_imm_o     (accumulator_imm),
        .reg_file_addr_o       (reg_file_addr)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        test_checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        test_errors++;
        $display("Failure in %s: %s", test_name, msg);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    // inputs change on the falling edge and outputs are read 2 ns later
    task automatic drive(input thumb_ctrl_pkg::instr_t code, input logic valid);
        @(negedge clk);
        instruction = code;
        is_valid    = valid;
        #2;
    endtask

    task automatic set_alu(input thumb_ctrl_pkg::alu_op_t op, input logic a_zero,
                           input logic b_imm, input logic write);
        exp_flag = 1'b1;
        exp_rw   = write;
        exp_op   = op;
        exp_a    = a_zero ? thumb_ctrl_pkg::SRC_ZERO : thumb_ctrl_pkg::SRC_REG;
        exp_b    = b_imm ? thumb_ctrl_pkg::SRC_IMM : thumb_ctrl_pkg::SRC_REG;
    endtask

    task automatic predict_single(input thumb_ctrl_pkg::instr_t code);
        exp_flag = 1'b0;
        exp_mw   = 1'b0;
        exp_mr   = 1'b0;
        exp_rw   = 1'b0;
        exp_src  = thumb_ctrl_pkg::WB_ALU;
        exp_a    = thumb_ctrl_pkg::SRC_REG;
        exp_b    = thumb_ctrl_pkg::SRC_REG;
        exp_op   = thumb_ctrl_pkg::ALU_ADD;
        if (code[15:14] == 2'b00) begin
            case (code[13:11])
                3'd0: set_alu(thumb_ctrl_pkg::ALU_LSL, 1'b0, 1'b1, 1'b1);
                3'd1: set_alu(thumb_ctrl_pkg::ALU_LSR, 1'b0, 1'b1, 1'b1);
                3'd2: set_alu(thumb_ctrl_pkg::ALU_ASR, 1'b0, 1'b1, 1'b1);
                3'd3: begin
                    if (code[9]) begin
                        set_alu(thumb_ctrl_pkg::ALU_SUB, 1'b0, code[10], 1'b1);
                    end else begin
                        set_alu(thumb_ctrl_pkg::ALU_ADD, 1'b0, code[10], 1'b1);
                    end
                end
                // MOV is 0 + imm
                3'd4: set_alu(thumb_ctrl_pkg::ALU_ADD, 1'b1, 1'b1, 1'b1);
                3'd5: set_alu(thumb_ctrl_pkg::ALU_SUB, 1'b0, 1'b1, 1'b0);
                3'd6: set_alu(thumb_ctrl_pkg::ALU_ADD, 1'b0, 1'b1, 1'b1);
                default: set_alu(thumb_ctrl_pkg::ALU_SUB, 1'b0, 1'b1, 1'b1);
            endcase
        end else if (code[15:10] == 6'b010000) begin
            case (code[9:6])
                4'd0:  set_alu(thumb_ctrl_pkg::ALU_AND, 1'b0, 1'b0, 1'b1);
                4'd1:  set_alu(thumb_ctrl_pkg::ALU_XOR, 1'b0, 1'b0, 1'b1);
                4'd2:  set_alu(thumb_ctrl_pkg::ALU_LSL, 1'b0, 1'b0, 1'b1);
                4'd3:  set_alu(thumb_ctrl_pkg::ALU_LSR, 1'b0, 1'b0, 1'b1);
                4'd4:  set_alu(thumb_ctrl_pkg::ALU_ASR, 1'b0, 1'b0, 1'b1);
                4'd5:  set_alu(thumb_ctrl_pkg::ALU_ADC, 1'b0, 1'b0, 1'b1);
                4'd6:  set_alu(thumb_ctrl_pkg::ALU_SBC, 1'b0, 1'b0, 1'b1);
                4'd7:  set_alu(thumb_ctrl_pkg::ALU_ROR, 1'b0, 1'b0, 1'b1);
                // TST, NEG, CMP and CMN
                4'd8:  set_alu(thumb_ctrl_pkg::ALU_AND, 1'b0, 1'b0, 1'b0);
                4'd9:  set_alu(thumb_ctrl_pkg::ALU_SUB, 1'b1, 1'b0, 1'b1);
                4'd10: set_alu(thumb_ctrl_pkg::ALU_SUB, 1'b0, 1'b0, 1'b0);
                4'd11: set_alu(thumb_ctrl_pkg::ALU_ADD, 1'b0, 1'b0, 1'b0);
                4'd12: set_alu(thumb_ctrl_pkg::ALU_OR, 1'b0, 1'b0, 1'b1);
                4'd13: set_alu(thumb_ctrl_pkg::ALU_MUL, 1'b0, 1'b0, 1'b1);
                4'd14: set_alu(thumb_ctrl_pkg::ALU_BIC, 1'b0, 1'b0, 1'b1);
                default: set_alu(thumb_ctrl_pkg::ALU_NOT, 1'b0, 1'b0, 1'b1);
            endcase
        end else if (code[15:13] == 3'b011) begin
            exp_b   = thumb_ctrl_pkg::SRC_IMM;
            exp_src = thumb_ctrl_pkg::WB_MEMORY;
            exp_mr  = code[11];
            exp_rw  = code[11];
            exp_mw  = !code[11];
        end
    endtask

    task automatic check_single(input thumb_ctrl_pkg::instr_t code);
        drive(code, 1'b1);
        predict_single(code);
        check("update_flag", exp_flag, update_flag);
        check("mem_write_en", exp_mw, mem_write_en);
        check("mem_read_en", exp_mr, mem_read_en);
        check("reg_write_en", exp_rw, reg_write_en);
        check("reg_data_src", exp_src, reg_data_src);
        check("alu_src_a", exp_a, alu_src_a);
        check("alu_src_b", exp_b, alu_src_b);
        check("alu_op", exp_op, alu_op);
        check("stall", 1'b0, stall);
        check("reg_addr_from_ctrl", 1'b0, reg_addr_from_ctrl);
        check("dest_addr_from_ctrl", 1'b0, dest_addr_from_ctrl);
        check("accumulator_imm", '0, accumulator_imm);
        check("reg_file_addr", '0, reg_file_addr);
    endtask

    // a negative stop_after walks the whole list and checks the final cycle
    task automatic walk_multi(input thumb_ctrl_pkg::instr_t code, input int stop_after);
        logic       load;
        logic [3:0] base;
        logic [3:0] order [8];
        int         n;
        int         k;
        int         pos;
        load = code[11];
        base = {1'b0, code[10:8]};
        n    = 0;
        for (int i = 0; i < 8; i++) begin
            if (code[i]) begin
                order[n] = 4'(i);
                n++;
            end
        end
        drive(code, 1'b1);
        k = 0;
        while (stall === 1'b1 && k < SEQ_TIMEOUT && k != stop_after) begin
            // STM runs upwards and LDM downwards, the offset is 4 times the slot either way
            pos = load ? (n - 1 - k) : k;
            check("stall", k < n, stall);
            check("reg_file_addr", order[pos[2:0]], reg_file_addr);
            check("accumulator_imm", 4 * pos, accumulator_imm);
            check("alu_src_b", thumb_ctrl_pkg::SRC_ACCUMULATOR, alu_src_b);
            check("mem_write_en", !load, mem_write_en);
            check("mem_read_en", 1'b0, mem_read_en);
            check("reg_write_en", load, reg_write_en);
            check("reg_data_src", load ? thumb_ctrl_pkg::WB_MEMORY : thumb_ctrl_pkg::WB_ALU,
                  reg_data_src);
            check("reg_addr_from_ctrl", !load, reg_addr_from_ctrl);
            check("dest_addr_from_ctrl", load, dest_addr_from_ctrl);
            drive(code, 1'b1);
            k++;
        end
        if (k != stop_after) begin
            if (stall === 1'b1) begin
                report_failure("stall stayed high for 20 cycles");
            end
            check("transfer cycles", n, k);
            check("stall", 1'b0, stall);
            check("reg_file_addr", base, reg_file_addr);
            check("accumulator_imm", 4 * n, accumulator_imm);
            check("alu_src_b", thumb_ctrl_pkg::SRC_ACCUMULATOR, alu_src_b);
            check("reg_data_src", thumb_ctrl_pkg::WB_ALU, reg_data_src);
            check("dest_addr_from_ctrl", 1'b1, dest_addr_from_ctrl);
            // a loaded base register keeps its memory value
            check("reg_write_en", !load || !code[base[2:0]], reg_write_en);
            check("mem_write_en", 1'b0, mem_write_en);
            check("mem_read_en", 1'b0, mem_read_en);
        end
    endtask

    initial begin
        lcg_state   = 32'd64;
        tests       = 0;
        checks      = 0;
        errors      = 0;
        // 0xE000 lies outside every kept group
        instruction = 16'hE000;
        is_valid    = 1'b0;

        start_test("reset_idle");
        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            report_failure("reset was never released");
        end
        @(negedge clk);
        #2;
        check("stall", 1'b0, stall);
        check("update_flag", 1'b0, update_flag);
        check("mem_write_en", 1'b0, mem_write_en);
        check("mem_read_en", 1'b0, mem_read_en);
        check("reg_write_en", 1'b0, reg_write_en);
        finish_test();

        start_test("alu_decode");
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            if (r[31]) begin
                instr = {2'b00, r[29:16]};
            end else begin
                instr = {6'b010000, r[25:16]};
            end
            check_single(instr);
        end
        finish_test();

        start_test("load_store_and_other");
        for (int i = 0; i < 30; i++) begin
            r = next_random();
            if (r[31]) begin
                instr = {3'b011, r[28:16]};
            end else if (r[29:27] == 3'b100) begin
                // 0100 with bits 11:10 not zero is not data processing
                instr = {6'b010001, r[25:16]};
            end else begin
                instr = {1'b1, r[29:27], r[27:16]};
            end
            check_single(instr);
        end
        finish_test();

        start_test("stm_walk");
        for (int i = 0; i < 10; i++) begin
            r = next_random();
            walk_multi({5'b11000, r[26:24], r[23:16]}, -1);
        end
        walk_multi({5'b11000, 3'd2, 8'h00}, -1);
        finish_test();

        start_test("ldm_walk");
        for (int i = 0; i < 10; i++) begin
            r = next_random();
            instr = {5'b11001, r[26:24], r[23:16]};
            // every other list names its own base register
            if (i[0] == 1'b0) begin
                instr[r[26:24]] = 1'b1;
            end
            walk_multi(instr, -1);
        end
        walk_multi({5'b11001, 3'd5, 8'h00}, -1);
        finish_test();

        start_test("valid_drop_restart");
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            instr = {4'b1100, i[0], r[26:24], r[23:16] | 8'h25};
            walk_multi(instr, 2);
            drive(instr, 1'b0);
            check("stall", 1'b0, stall);
            check("mem_write_en", 1'b0, mem_write_en);
            check("mem_read_en", 1'b0, mem_read_en);
            check("reg_write_en", 1'b0, reg_write_en);
            walk_multi(instr, -1);
        end
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/thumb_controller_props.sv ====
`timescale 1ns/1ps

module thumb_controller_props (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   is_valid_i,
    input thumb_ctrl_pkg::instr_t instruction_i,
    input logic                   stall_i,
    input logic                   mem_write_en_i,
    input logic                   mem_read_en_i
);

    logic final_cycle;

    // the cycle after the register list, when only the base register is updated
    assign final_cycle = is_valid_i && (instruction_i[15:12] == 4'b1100) && !stall_i;

    stall_needs_valid: assert property (
        @(posedge clk_i) disable iff (reset_i) !is_valid_i |-> !stall_i
    ) else $error("stall_o high while is_valid_i is low");

    one_mem_enable: assert property (
        @(posedge clk_i) disable iff (reset_i) !(mem_write_en_i && mem_read_en_i)
    ) else $error("memory read and write enabled in the same cycle");

    quiet_final_cycle: assert property (
        @(posedge clk_i) disable iff (reset_i)
            final_cycle |-> (!mem_write_en_i && !mem_read_en_i)
    ) else $error("memory access in the LDM/STM final cycle");

endmodule

bind thumb_controller thumb_controller_props u_props (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .is_valid_i     (is_valid_i),
    .instruction_i  (instruction_i),
    .stall_i        (stall_o),
    .mem_write_en_i (mem_write_en_o),
    .mem_read_en_i  (mem_read_en_o)
);

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // reset covers four rising edges and is released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// ==== rtl/thumb_controller.sv ====
`timescale 1ns/1ps

module thumb_controller (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          is_valid_i,
    input  thumb_ctrl_pkg::instr_t        instruction_i,

    output logic                          update_flag_o,
    output logic                          mem_write_en_o,
    output logic                          mem_read_en_o,
    output logic                          reg_write_en_o,
    output thumb_ctrl_pkg::reg_data_src_t reg_data_src_o,
    output thumb_ctrl_pkg::alu_src_t      alu_src_a_o,
    output thumb_ctrl_pkg::alu_src_t      alu_src_b_o,
    output thumb_ctrl_pkg::alu_op_t       alu_op_o,
    output logic                          stall_o,
    output logic                          reg_addr_from_ctrl_o,
    output logic                          dest_addr_from_ctrl_o,
    output thumb_ctrl_pkg::word_t         accumulator_imm_o,
    output thumb_ctrl_pkg::reg_addr_t     reg_file_addr_o
);

    logic                          dec_update_flag;
    logic                          dec_mem_write_en;
    logic                          dec_mem_read_en;
    logic                          dec_reg_write_en;
    thumb_ctrl_pkg::reg_data_src_t dec_reg_data_src;
    thumb_ctrl_pkg::alu_src_t      dec_alu_src_a;
    thumb_ctrl_pkg::alu_src_t      dec_alu_src_b;
    thumb_ctrl_pkg::alu_op_t       dec_alu_op;
    logic                          dec_is_multi;
    logic                          dec_multi_load;

    logic                          seq_stall;
    logic                          seq_transfer;
    logic                          seq_writeback_en;
    thumb_ctrl_pkg::reg_addr_t     seq_reg_file_addr;
    thumb_ctrl_pkg::word_t         seq_accumulator_imm;

    thumb_instr_decode u_decode (
        .instruction_i  (instruction_i),
        .update_flag_o  (dec_update_flag),
        .mem_write_en_o (dec_mem_write_en),
        .mem_read_en_o  (dec_mem_read_en),
        .reg_write_en_o (dec_reg_write_en),
        .reg_data_src_o (dec_reg_data_src),
        .alu_src_a_o    (dec_alu_src_a),
        .alu_src_b_o    (dec_alu_src_b),
        .alu_op_o       (dec_alu_op),
        .is_multi_o     (dec_is_multi),
        .multi_load_o   (dec_multi_load)
    );

    multi_transfer_sequencer u_sequencer (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .active_i          (dec_is_multi && is_valid_i),
        .load_i            (dec_multi_load),
        .base_reg_i        (thumb_ctrl_pkg::reg_addr_t'(instruction_i[10:8])),
        .reg_list_i        (instruction_i[7:0]),
        .stall_o           (seq_stall),
        .transfer_o        (seq_transfer),
        .writeback_en_o    (seq_writeback_en),
        .reg_file_addr_o   (seq_reg_file_addr),
        .accumulator_imm_o (seq_accumulator_imm)
    );

    always_comb begin
        if (dec_is_multi) begin
            // LDM/STM drives the ALU with base plus the sequencer offset
            update_flag_o         = 1'b0;
            mem_write_en_o        = seq_transfer && !dec_multi_load;
            mem_read_en_o         = 1'b0;
            reg_write_en_o        = (seq_transfer && dec_multi_load) || seq_writeback_en;
            reg_data_src_o        = (seq_transfer && dec_multi_load) ?
                                    thumb_ctrl_pkg::WB_MEMORY : thumb_ctrl_pkg::WB_ALU;
            alu_src_a_o           = thumb_ctrl_pkg::SRC_REG;
            alu_src_b_o           = thumb_ctrl_pkg::SRC_ACCUMULATOR;
            alu_op_o              = thumb_ctrl_pkg::ALU_ADD;
            stall_o               = seq_stall;
            reg_addr_from_ctrl_o  = seq_transfer && !dec_multi_load;
            // LDM targets listed registers, STM only targets the base at the end
            dest_addr_from_ctrl_o = dec_multi_load || !seq_stall;
            accumulator_imm_o     = seq_accumulator_imm;
            reg_file_addr_o       = seq_reg_file_addr;
        end else begin
            update_flag_o         = dec_update_flag;
            mem_write_en_o        = dec_mem_write_en;
            mem_read_en_o         = dec_mem_read_en;
            reg_write_en_o        = dec_reg_write_en;
            reg_data_src_o        = dec_reg_data_src;
            alu_src_a_o           = dec_alu_src_a;
            alu_src_b_o           = dec_alu_src_b;
            alu_op_o              = dec_alu_op;
            stall_o               = 1'b0;
            reg_addr_from_ctrl_o  = 1'b0;
            dest_addr_from_ctrl_o = 1'b0;
            accumulator_imm_o     = '0;
            reg_file_addr_o       = '0;
        end
    end

endmodule

// ==== rtl/multi_transfer_sequencer.sv ====
`timescale 1ns/1ps

`include "thumb_ctrl_config.svh"

module multi_transfer_sequencer (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        active_i,
    input  logic                        load_i,
    input  thumb_ctrl_pkg::reg_addr_t   base_reg_i,
    input  thumb_ctrl_pkg::reg_list_t   reg_list_i,

    output logic                        stall_o,
    output logic                        transfer_o,
    output logic                        writeback_en_o,
    output thumb_ctrl_pkg::reg_addr_t   reg_file_addr_o,
    output thumb_ctrl_pkg::word_t       accumulator_imm_o
);

    localparam int LIST_W = `THUMB_REG_LIST_W;
    localparam int IDX_W  = $clog2(LIST_W);

    // registers of the list that still have to be transferred
    thumb_ctrl_pkg::reg_list_t   mask_q;
    thumb_ctrl_pkg::xfer_count_t count_q;

    thumb_ctrl_pkg::reg_list_t   remaining;
    thumb_ctrl_pkg::reg_list_t   pick_onehot;
    thumb_ctrl_pkg::xfer_count_t list_count;
    thumb_ctrl_pkg::xfer_count_t slot;
    logic [IDX_W-1:0]            low_idx;
    logic [IDX_W-1:0]            high_idx;
    logic [IDX_W-1:0]            pick_idx;
    logic                        base_in_list;

    assign remaining = reg_list_i & mask_q;

    // stall as long as any listed register is left
    assign stall_o    = active_i && (remaining != '0);
    assign transfer_o = stall_o;

    always_comb begin
        low_idx    = '0;
        high_idx   = '0;
        list_count = '0;
        // downward scan leaves the lowest set bit, upward scan the highest
        for (int i = LIST_W - 1; i >= 0; i--) begin
            if (remaining[i]) begin
                low_idx = IDX_W'(i);
            end
        end
        for (int i = 0; i < LIST_W; i++) begin
            if (remaining[i]) begin
                high_idx = IDX_W'(i);
            end
            if (reg_list_i[i]) begin
                list_count = list_count + 4'd1;
            end
        end
    end

    // STM walks upwards through the list and LDM walks downwards
    assign pick_idx    = load_i ? high_idx : low_idx;
    assign pick_onehot = thumb_ctrl_pkg::reg_list_t'(1) << pick_idx;

    // LDM fills from the top of the block, so its slot counts down from N-1
    assign slot = load_i ? (list_count - 4'd1 - count_q) : count_q;

    assign base_in_list = (base_reg_i < thumb_ctrl_pkg::reg_addr_t'(LIST_W)) &&
                          reg_list_i[base_reg_i[IDX_W-1:0]];

    always_comb begin
        if (stall_o) begin
            reg_file_addr_o   = thumb_ctrl_pkg::reg_addr_t'(pick_idx);
            accumulator_imm_o = thumb_ctrl_pkg::word_t'(slot) * `THUMB_XFER_BYTES;
        end else begin
            // final cycle moves the base register on by the whole block
            reg_file_addr_o   = base_reg_i;
            accumulator_imm_o = thumb_ctrl_pkg::word_t'(list_count) * `THUMB_XFER_BYTES;
        end
    end

    // a loaded base register keeps the value read from memory
    assign writeback_en_o = active_i && !stall_o && (!load_i || !base_in_list);

    always_ff @(posedge clk_i) begin
        if (reset_i || !active_i || !stall_o) begin
            mask_q  <= '1;
            count_q <= '0;
        end else begin
            mask_q  <= mask_q & ~pick_onehot;
            count_q <= count_q + 4'd1;
        end
    end

endmodule

// ==== rtl/thumb_instr_decode.sv ====
`timescale 1ns/1ps

module thumb_instr_decode (
    input  thumb_ctrl_pkg::instr_t        instruction_i,

    output logic                          update_flag_o,
    output logic                          mem_write_en_o,
    output logic                          mem_read_en_o,
    output logic                          reg_write_en_o,
    output thumb_ctrl_pkg::reg_data_src_t reg_data_src_o,
    output thumb_ctrl_pkg::alu_src_t      alu_src_a_o,
    output thumb_ctrl_pkg::alu_src_t      alu_src_b_o,
    output thumb_ctrl_pkg::alu_op_t       alu_op_o,
    output logic                          is_multi_o,
    output logic                          multi_load_o
);

    // group 00 sub-opcodes from bits 13:11
    localparam logic [2:0] SH_LSL_IMM = 3'b000;
    localparam logic [2:0] SH_LSR_IMM = 3'b001;
    localparam logic [2:0] SH_ASR_IMM = 3'b010;
    localparam logic [2:0] SH_ADD_SUB = 3'b011;
    localparam logic [2:0] SH_MOV_IMM = 3'b100;
    localparam logic [2:0] SH_CMP_IMM = 3'b101;
    localparam logic [2:0] SH_ADD_IMM = 3'b110;
    localparam logic [2:0] SH_SUB_IMM = 3'b111;

    logic [2:0] shift_code;
    logic [3:0] dp_code;

    assign shift_code = instruction_i[13:11];
    assign dp_code    = instruction_i[9:6];

    // LDM/STM is only flagged here, the sequencing happens on the execute side
    assign is_multi_o   = (instruction_i[15:12] == 4'b1100);
    assign multi_load_o = instruction_i[11];

    always_comb begin
        update_flag_o  = 1'b0;
        mem_write_en_o = 1'b0;
        mem_read_en_o  = 1'b0;
        reg_write_en_o = 1'b0;
        reg_data_src_o = thumb_ctrl_pkg::WB_ALU;
        alu_src_a_o    = thumb_ctrl_pkg::SRC_REG;
        alu_src_b_o    = thumb_ctrl_pkg::SRC_REG;
        alu_op_o       = thumb_ctrl_pkg::ALU_ADD;

        casez (instruction_i[15:10])
            6'b00????: begin
                // nearly every instruction here updates flags and writes a register
                update_flag_o  = 1'b1;
                reg_write_en_o = 1'b1;
                case (shift_code)
                    SH_LSL_IMM: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_LSL;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    SH_LSR_IMM: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_LSR;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    SH_ASR_IMM: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_ASR;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    SH_ADD_SUB: begin
                        // bit 10 selects the 3-bit immediate form, bit 9 selects subtract
                        if (instruction_i[9]) begin
                            alu_op_o = thumb_ctrl_pkg::ALU_SUB;
                        end
                        if (instruction_i[10]) begin
                            alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                        end
                    end
                    SH_MOV_IMM: begin
                        alu_src_a_o = thumb_ctrl_pkg::SRC_ZERO;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    SH_CMP_IMM: begin
                        alu_op_o       = thumb_ctrl_pkg::ALU_SUB;
                        alu_src_b_o    = thumb_ctrl_pkg::SRC_IMM;
                        reg_write_en_o = 1'b0;
                    end
                    SH_ADD_IMM: begin
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    SH_SUB_IMM: begin
                        alu_op_o    = thumb_ctrl_pkg::ALU_SUB;
                        alu_src_b_o = thumb_ctrl_pkg::SRC_IMM;
                    end
                    default: ;
                endcase
            end
            6'b010000: begin
                update_flag_o  = 1'b1;
                reg_write_en_o = 1'b1;
                case (dp_code)
                    4'd0:  alu_op_o = thumb_ctrl_pkg::ALU_AND;
                    4'd1:  alu_op_o = thumb_ctrl_pkg::ALU_XOR;
                    4'd2:  alu_op_o = thumb_ctrl_pkg::ALU_LSL;
                    4'd3:  alu_op_o = thumb_ctrl_pkg::ALU_LSR;
                    4'd4:  alu_op_o = thumb_ctrl_pkg::ALU_ASR;
                    4'd5:  alu_op_o = thumb_ctrl_pkg::ALU_ADC;
                    4'd6:  alu_op_o = thumb_ctrl_pkg::ALU_SBC;
                    4'd7:  alu_op_o = thumb_ctrl_pkg::ALU_ROR;
                    4'd8: begin
                        // TST only sets flags
                        alu_op_o       = thumb_ctrl_pkg::ALU_AND;
                        reg_write_en_o = 1'b0;
                    end
                    4'd9: begin
                        // NEG is computed as 0 - Rm
                        alu_op_o    = thumb_ctrl_pkg::ALU_SUB;
                        alu_src_a_o = thumb_ctrl_pkg::SRC_ZERO;
                    end
                    4'd10: begin
                        alu_op_o       = thumb_ctrl_pkg::ALU_SUB;
                        reg_write_en_o = 1'b0;
                    end
                    4'd11: begin
                        alu_op_o       = thumb_ctrl_pkg::ALU_ADD;
                        reg_write_en_o = 1'b0;
                    end
                    4'd12: alu_op_o = thumb_ctrl_pkg::ALU_OR;
                    4'd13: alu_op_o = thumb_ctrl_pkg::ALU_MUL;
                    4'd14: alu_op_o = thumb_ctrl_pkg::ALU_BIC;
                    default: alu_op_o = thumb_ctrl_pkg::ALU_NOT;
                endcase
            end
            6'b011???: begin
                // address is base plus immediate, bit 11 picks load over store
                alu_src_b_o    = thumb_ctrl_pkg::SRC_IMM;
                reg_data_src_o = thumb_ctrl_pkg::WB_MEMORY;
                if (instruction_i[11]) begin
                    mem_read_en_o  = 1'b1;
                    reg_write_en_o = 1'b1;
                end else begin
                    mem_write_en_o = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/thumb_ctrl_pkg.sv ====
`include "thumb_ctrl_config.svh"

package thumb_ctrl_pkg;

    // raw instruction as fetched
    typedef logic [`THUMB_INSTR_W-1:0] instr_t;

    // data word, also used for immediates and accumulator offsets
    typedef logic [`THUMB_WORD_W-1:0] word_t;

    // register file address, wide enough for all sixteen registers
    typedef logic [3:0] reg_addr_t;

    // LDM/STM register list taken from bits 7:0
    typedef logic [`THUMB_REG_LIST_W-1:0] reg_list_t;

    // number of registers moved so far in a multiple transfer
    typedef logic [3:0] xfer_count_t;

    // operation selected for the ALU
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_XOR = 4'd3,
        ALU_OR  = 4'd4,
        ALU_LSL = 4'd5,
        ALU_LSR = 4'd6,
        ALU_ASR = 4'd7,
        ALU_ROR = 4'd8,
        ALU_ADC = 4'd9,
        ALU_SBC = 4'd10,
        ALU_MUL = 4'd11,
        ALU_BIC = 4'd12,
        ALU_NOT = 4'd13
    } alu_op_t;

    // where an ALU operand comes from
    // the accumulator source carries the controller's offset during LDM/STM
    typedef enum logic [1:0] {
        SRC_REG         = 2'd0,
        SRC_IMM         = 2'd1,
        SRC_ZERO        = 2'd2,
        SRC_ACCUMULATOR = 2'd3
    } alu_src_t;

    // source of the data written back into the register file
    typedef enum logic {
        WB_ALU    = 1'b0,
        WB_MEMORY = 1'b1
    } reg_data_src_t;

endpackage

// ==== rtl/thumb_ctrl_config.svh ====
`ifndef THUMB_CTRL_CONFIG_SVH
`define THUMB_CTRL_CONFIG_SVH

// width of a data word on the execute side
`define THUMB_WORD_W 32

// width of one Thumb instruction
`define THUMB_INSTR_W 16

// LDM/STM register list covers the low registers only
`define THUMB_REG_LIST_W 8

// bytes moved per register in a multiple transfer
`define THUMB_XFER_BYTES 4

`endif
